//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_slow_mem
FILELIST  ?= slow_mem_top.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

//--- logic/mem_responder.sv
// Slow memory responder
// Serves the queue head after a fixed wait, owns the array, drives rvalid/rdata

`timescale 1ns/1ps
`default_nettype none

module mem_responder (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            valid_i,
  input  slow_mem_pkg::pend_req_t         head_i,
  output logic                            pop_o,
  output logic                            rsp_valid_o,
  output logic [slow_mem_pkg::DATA_W-1:0] rsp_data_o
);

  logic [slow_mem_pkg::DATA_W-1:0] mem_q [slow_mem_pkg::MEM_WORDS];

  logic                               busy_q;
  logic [slow_mem_pkg::LAT_CNT_W-1:0] wait_cnt_q;
  logic                               serve;
  logic                               rsp_valid_q;
  logic [slow_mem_pkg::DATA_W-1:0]    rsp_data_q;

  // Last wait cycle, head is answered and released on this edge
  assign serve = busy_q && (wait_cnt_q == slow_mem_pkg::LAT_LAST);
  assign pop_o = serve;

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;

  // ----------------------------------------------------------------------
  // Wait sequencing
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      wait_cnt_q  <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= serve;
      if (!busy_q) begin
        // Idle, pick up the head
        if (valid_i) begin
          busy_q     <= 1'b1;
          wait_cnt_q <= '0;
        end
      end else if (serve) begin
        busy_q <= 1'b0;
      end else begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Array access
  // ----------------------------------------------------------------------
  // Read returns the old word, misses read as zero
  always_ff @(posedge clk_i) begin
    if (serve) begin
      if (head_i.hit) begin
        rsp_data_q <= mem_q[head_i.word_idx];
      end else begin
        rsp_data_q <= '0;
      end
    end
  end

  // Byte-enable merge, hits only
  always_ff @(posedge clk_i) begin
    if (serve && head_i.hit && head_i.we) begin
      for (int b = 0; b < slow_mem_pkg::BE_W; b++) begin
        if (head_i.be[b]) begin
          mem_q[head_i.word_idx][8*b +: 8] <= head_i.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/obi_req_frontend.sv
// Request front end of the slow memory
// Grants a request while the queue has room and tags it with its window hit

`timescale 1ns/1ps
`default_nettype none

module obi_req_frontend (
  input  slow_mem_pkg::bus_req_t  req_i,
  input  logic                    queue_full_i,
  output logic                    gnt_o,
  output logic                    push_o,
  output slow_mem_pkg::pend_req_t pend_o
);

  logic grant;
  logic win_hit;

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------
  // Combinational, so a held request goes through as soon as a slot frees
  assign grant  = req_i.req && !queue_full_i;
  assign gnt_o  = grant;

  // Every accepted request lands in the queue
  assign push_o = grant;

  // ----------------------------------------------------------------------
  // Window decode
  // ----------------------------------------------------------------------
  assign win_hit = (req_i.addr.fields.tag == slow_mem_pkg::WINDOW_TAG);

  always_comb begin
    pend_o          = '0;
    pend_o.hit      = win_hit;
    pend_o.we       = req_i.we;
    pend_o.be       = req_i.be;
    pend_o.word_idx = req_i.addr.fields.word_idx;
    pend_o.wdata    = req_i.wdata;
  end

endmodule

`default_nettype wire

//--- logic/req_queue.sv
// Pending-request queue
// Circular buffer that keeps granted requests in order for the responder

`timescale 1ns/1ps
`default_nettype none

module req_queue (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    push_i,
  input  slow_mem_pkg::pend_req_t pend_i,
  input  logic                    pop_i,
  output logic                    full_o,
  output logic                    valid_o,
  output slow_mem_pkg::pend_req_t head_o
);

  slow_mem_pkg::pend_req_t entries_q [slow_mem_pkg::QUEUE_DEPTH];

  logic [slow_mem_pkg::QPTR_W-1:0] wr_ptr_q;
  logic [slow_mem_pkg::QPTR_W-1:0] rd_ptr_q;
  logic [slow_mem_pkg::QCNT_W-1:0] count_q;
  logic                            full;
  logic                            empty;
  logic                            do_push;
  logic                            do_pop;

  assign full    = (count_q == slow_mem_pkg::QCNT_FULL);
  assign empty   = (count_q == '0);
  assign full_o  = full;
  assign valid_o = !empty;
  assign head_o  = entries_q[rd_ptr_q];

  // When full, a push only fits if the head leaves on the same edge
  assign do_push = push_i && (!full || pop_i);
  assign do_pop  = pop_i && !empty;

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == slow_mem_pkg::QPTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == slow_mem_pkg::QPTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      entries_q[wr_ptr_q] <= pend_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/slow_mem_pkg.sv
// Slow external memory slave, shared definitions
// Sizes, address window, response latency and the bus and queue types

`default_nettype none

package slow_mem_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int BE_W      = 4;
  localparam int MEM_WORDS = 256;
  localparam int OFFS_W    = $clog2(BE_W);
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int TAG_W     = ADDR_W - IDX_W - OFFS_W;

  // Window at 32'h2000_0000, 1 KiB
  localparam logic [TAG_W-1:0] WINDOW_TAG = 22'h08_0000;

  // Pending-request queue
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
  localparam logic [QPTR_W-1:0] QPTR_LAST = QPTR_W'(QUEUE_DEPTH - 1);
  localparam logic [QCNT_W-1:0] QCNT_FULL = QCNT_W'(QUEUE_DEPTH);

  // Wait cycles before each response, at least one
  localparam int RESP_LATENCY = 3;
  localparam int LAT_CNT_W    = $clog2(RESP_LATENCY + 1);
  localparam logic [LAT_CNT_W-1:0] LAT_LAST = LAT_CNT_W'(RESP_LATENCY - 1);

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  word_idx;
    logic [OFFS_W-1:0] offset;
  } addr_fields_t;

  // Same address word, raw or split
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    addr_fields_t      fields;
  } mem_addr_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    mem_addr_t         addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Queue entry
  typedef struct packed {
    logic              hit;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [IDX_W-1:0]  word_idx;
    logic [DATA_W-1:0] wdata;
  } pend_req_t;

endpackage

`default_nettype wire

//--- logic/slow_mem_top.sv
// Slow external memory slave
// Front end, pending-request queue and delayed responder behind one bus port

`timescale 1ns/1ps
`default_nettype none

module slow_mem_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  slow_mem_pkg::bus_req_t bus_req_i,
  output slow_mem_pkg::bus_rsp_t bus_rsp_o
);

  logic                            gnt;
  logic                            push;
  logic                            queue_full;
  logic                            queue_valid;
  logic                            pop;
  logic                            rsp_valid;
  logic [slow_mem_pkg::DATA_W-1:0] rsp_data;
  slow_mem_pkg::pend_req_t         pend;
  slow_mem_pkg::pend_req_t         head;

  obi_req_frontend i_frontend (
    .req_i        (bus_req_i),
    .queue_full_i (queue_full),
    .gnt_o        (gnt),
    .push_o       (push),
    .pend_o       (pend)
  );

  req_queue i_queue (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (push),
    .pend_i  (pend),
    .pop_i   (pop),
    .full_o  (queue_full),
    .valid_o (queue_valid),
    .head_o  (head)
  );

  mem_responder i_responder (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (queue_valid),
    .head_i      (head),
    .pop_o       (pop),
    .rsp_valid_o (rsp_valid),
    .rsp_data_o  (rsp_data)
  );

  // Response bus
  assign bus_rsp_o.gnt    = gnt;
  assign bus_rsp_o.rvalid = rsp_valid;
  assign bus_rsp_o.rdata  = rsp_data;

endmodule

`default_nettype wire

//--- slow_mem_top.f
logic/slow_mem_pkg.sv
logic/obi_req_frontend.sv
logic/req_queue.sv
logic/mem_responder.sv
logic/slow_mem_top.sv
tb/slow_mem_checker.sv
tb/slow_mem_assert.sv
tb/tb_slow_mem.sv

//--- tb/slow_mem_assert.sv
// Handshake assertions for the slow memory slave
// Bound into the top level

`timescale 1ns/1ps
`default_nettype none

module slow_mem_assert (
  input logic                   clk_i,
  input logic                   rst_i,
  input slow_mem_pkg::bus_req_t bus_req_i,
  input slow_mem_pkg::bus_rsp_t bus_rsp_i
);

  int acc_cnt;
  int rsp_cnt;
  int fail_cnt = 0;

  always @(posedge clk_i) begin
    if (rst_i) begin
      acc_cnt <= 0;
      rsp_cnt <= 0;
    end else begin
      if (bus_req_i.req && bus_rsp_i.gnt) begin
        acc_cnt <= acc_cnt + 1;
      end
      if (bus_rsp_i.rvalid) begin
        rsp_cnt <= rsp_cnt + 1;
      end
    end
  end

  gnt_needs_req: assert property (
    @(posedge clk_i) disable iff (rst_i) bus_rsp_i.gnt |-> bus_req_i.req
  ) else begin
    $error("gnt high while req is low");
    fail_cnt++;
  end

  rvalid_single: assert property (
    @(posedge clk_i) disable iff (rst_i) bus_rsp_i.rvalid |=> !bus_rsp_i.rvalid
  ) else begin
    $error("rvalid held for more than one cycle");
    fail_cnt++;
  end

  // Responses never run ahead of accepted requests
  rsp_not_ahead: assert property (
    @(posedge clk_i) disable iff (rst_i) (rsp_cnt + int'(bus_rsp_i.rvalid)) <= acc_cnt
  ) else begin
    $error("more rvalid pulses than accepted requests");
    fail_cnt++;
  end

endmodule

bind slow_mem_top slow_mem_assert i_assert (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .bus_req_i (bus_req_i),
  .bus_rsp_i (bus_rsp_o)
);

`default_nettype wire

//--- tb/slow_mem_checker.sv
// Response checker for the slow memory slave
// Mirrors the array, predicts each read word and compares rdata in grant order

`timescale 1ns/1ps
`default_nettype none

module slow_mem_checker (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  slow_mem_pkg::bus_req_t bus_req_i,
  input  slow_mem_pkg::bus_rsp_t bus_rsp_i,
  output int                     err_cnt_o,
  output int                     pending_o,
  output int                     rsp_cnt_o
);

  // Window of 1 KiB of 32-bit words at 0x2000_0000
  localparam logic [31:0] WINDOW_BASE = 32'h2000_0000;
  localparam int          LATENCY    = slow_mem_pkg::RESP_LATENCY + 2;

  logic [31:0] mirror [256];
  logic [31:0] exp_q [$];
  int          due_q [$];
  int          cycle;

  function automatic void ref_access(input logic hit, input logic we, input logic [3:0] be,
                                     input logic [31:0] wdata, input logic [31:0] old_word,
                                     output logic [31:0] rd_word, output logic [31:0] new_word);
    rd_word  = hit ? old_word : 32'h0;
    new_word = old_word;
    if (hit && we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          new_word[8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
  endfunction

  always @(posedge clk_i) begin
    logic        hit;
    logic [7:0]  idx;
    logic [31:0] rd_word;
    logic [31:0] new_word;
    logic [31:0] exp_word;
    logic        exp_gnt;
    int          due;
    if (rst_i) begin
      cycle     = 0;
      err_cnt_o = 0;
      rsp_cnt_o = 0;
      exp_q.delete();
      due_q.delete();
    end else begin
      cycle = cycle + 1;
      // -------------------------------------------------------------------
      // Responses go first so a grant on the same edge sees the drained list
      // -------------------------------------------------------------------
      if (bus_rsp_i.rvalid) begin
        rsp_cnt_o = rsp_cnt_o + 1;
        if (exp_q.size() == 0) begin
          $display("Error at %0t: rvalid arrived with no request outstanding", $time);
          err_cnt_o = err_cnt_o + 1;
        end else begin
          exp_word = exp_q.pop_front();
          due      = due_q.pop_front();
          if (bus_rsp_i.rdata !== exp_word) begin
            $display("FAILED at %0t: bus_rsp_o.rdata = %08h, expected %08h",
                     $time, bus_rsp_i.rdata, exp_word);
            err_cnt_o = err_cnt_o + 1;
          end
          if (due >= 0 && due != cycle) begin
            $display("FAILED at %0t: bus_rsp_o.rvalid after %0d cycles, expected %0d",
                     $time, cycle - due + LATENCY, LATENCY);
            err_cnt_o = err_cnt_o + 1;
          end
        end
      end
      // Requests granted and not yet answered still occupy the queue
      exp_gnt = bus_req_i.req && (exp_q.size() < slow_mem_pkg::QUEUE_DEPTH);
      if (bus_rsp_i.gnt !== exp_gnt) begin
        $display("FAILED at %0t: bus_rsp_o.gnt = %0b, expected %0b",
                 $time, bus_rsp_i.gnt, exp_gnt);
        err_cnt_o = err_cnt_o + 1;
      end
      if (bus_req_i.req && bus_rsp_i.gnt) begin
        hit = (bus_req_i.addr.raw[31:10] == WINDOW_BASE[31:10]);
        idx = bus_req_i.addr.raw[9:2];
        ref_access(hit, bus_req_i.we, bus_req_i.be, bus_req_i.wdata, mirror[idx],
                   rd_word, new_word);
        mirror[idx] = new_word;
        // Fixed latency only holds when nothing is ahead in line
        due = (exp_q.size() == 0) ? cycle + LATENCY : -1;
        exp_q.push_back(rd_word);
        due_q.push_back(due);
      end
      pending_o = exp_q.size();
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_slow_mem.sv
// Testbench for the slow external memory slave
// Clock, reset, LFSR stimulus, directed and random tests, cycle timeout

`timescale 1ns/1ps
`default_nettype none

module tb_slow_mem;

  localparam int          CLK_PERIOD  = 40;
  localparam int          DRIVE_DLY   = 2;
  localparam int          RST_CYCLES  = 8;
  localparam logic [31:0] BASE        = 32'h2000_0000;
  localparam int          TOTAL_REQS  = 16 + 16 + 12 + 17 + 256 + 200;
  localparam int          CYCLE_LIMIT = TOTAL_REQS * (slow_mem_pkg::RESP_LATENCY + 2)
                                        * slow_mem_pkg::QUEUE_DEPTH + RST_CYCLES + 500;

  logic                   clk_i;
  logic                   rst_i;
  slow_mem_pkg::bus_req_t bus_req;
  slow_mem_pkg::bus_rsp_t bus_rsp;
  logic [31:0]            lfsr_state;
  int                     chk_errs;
  int                     pending;
  int                     rsp_cnt;
  int                     tb_errs;
  int                     req_cnt;
  int                     stall_cnt;
  int                     errs_before;
  int                     cycles;

  slow_mem_top i_dut (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp)
  );

  slow_mem_checker i_checker (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_req_i (bus_req),
    .bus_rsp_i (bus_rsp),
    .err_cnt_o (chk_errs),
    .pending_o (pending),
    .rsp_cnt_o (rsp_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: no end of run after %0d cycles", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    logic [7:0] a;
    a = 8'(idx);
    return {a, ~a, a ^ 8'h5a, a + 8'h3c};
  endfunction

  // Checker mismatches, directed checks and assertion failures
  function automatic int total_errors();
    return chk_errs + tb_errs + i_dut.i_assert.fail_cnt;
  endfunction

  // Starts just after a rising edge and holds the request until gnt
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata);
    bus_req.req      = 1'b1;
    bus_req.we       = we;
    bus_req.be       = be;
    bus_req.addr.raw = addr;
    bus_req.wdata    = wdata;
    @(negedge clk_i);
    while (!bus_rsp.gnt) begin
      stall_cnt++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    bus_req.req = 1'b0;
    req_cnt++;
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (pending != 0) @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic finish_test(input int num, input string name);
    wait_idle();
    $display("Test %0d %s done, %0d errors", num, name, total_errors() - errs_before);
    errs_before = total_errors();
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] data;
    int          stalls;
    bus_req     = '0;
    rst_i       = 1'b1;
    lfsr_state  = 32'h086d_03a8;
    tb_errs     = 0;
    req_cnt     = 0;
    stall_cnt   = 0;
    errs_before = 0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;

    for (int i = 0; i < 8; i++) bus_access(1'b1, 4'hf, BASE + 36 * i, rand_bits(32));
    for (int i = 0; i < 8; i++) bus_access(1'b0, 4'hf, BASE + 36 * i, 32'h0);
    finish_test(1, "full-word writes");

    for (int i = 0; i < 8; i++) bus_access(1'b1, 4'(rand_bits(4)), BASE + 36 * i, rand_bits(32));
    for (int i = 0; i < 8; i++) bus_access(1'b0, 4'hf, BASE + 36 * i, 32'h0);
    finish_test(2, "byte-enable writes");

    // Same word indices as above with tags outside the window
    for (int i = 0; i < 4; i++) bus_access(1'b1, 4'hf, 32'h2000_0400 + 36 * i, rand_bits(32));
    for (int i = 0; i < 4; i++) bus_access(1'b0, 4'hf, 32'h1fff_fc00 + 36 * i, 32'h0);
    for (int i = 0; i < 4; i++) bus_access(1'b0, 4'hf, BASE + 36 * i, 32'h0);
    finish_test(3, "out-of-window access");

    stalls = stall_cnt;
    for (int i = 0; i < 8; i++) bus_access(1'b1, 4'hf, BASE + 4 * (100 + i), rand_bits(32));
    for (int i = 0; i < 8; i++) bus_access(1'b0, 4'hf, BASE + 4 * (100 + i), 32'h0);
    if (stall_cnt == stalls) begin
      $display("Error at %0t: gnt never dropped during the back-to-back burst", $time);
      tb_errs++;
    end
    wait_idle();
    bus_access(1'b0, 4'hf, BASE + 4 * 100, 32'h0);
    finish_test(4, "burst and back-pressure");

    for (int i = 0; i < 256; i++) bus_access(1'b1, 4'hf, BASE + 4 * i, fill_word(i));
    for (int i = 0; i < 200; i++) begin
      if (rand_bits(2) != 0) begin
        addr = {BASE[31:10], 10'(rand_bits(10))};
      end else begin
        addr = rand_bits(32);
      end
      we   = 1'(rand_bits(1));
      be   = 4'(rand_bits(4));
      data = rand_bits(32);
      bus_access(we, be, addr, data);
    end
    finish_test(5, "random mixed traffic");

    $display("Tests: 5, requests: %0d, responses: %0d, errors: %0d",
             req_cnt, rsp_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
